// File: src/axil_mem_pkg.sv
//--------------------
// Widths, memory size, response codes and types for the AXI4-Lite memory
// Used by scoped names from every RTL file
//--------------------
package axil_mem_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;          // One strobe per byte lane

    // Memory geometry
    localparam int MEM_WORDS = 1024;
    localparam int INDEX_W   = $clog2(MEM_WORDS);
    localparam int unsigned MEM_BYTES = MEM_WORDS * STRB_W;  // First address out of range

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [STRB_W-1:0]  strb_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [1:0]         resp_t;

    // AXI response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Write front waits for both halves, then holds B
    typedef enum logic [0:0] {
        WR_COLLECT,
        WR_RESP
    } wr_state_t;

    // Read front takes one cycle in RAM before R
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_RESP
    } rd_state_t;

endpackage

// File: src/axil_write_front.sv
//--------------------
// AXI4-Lite write side: joins AW and W in any order, writes the RAM, answers on B
//--------------------
`timescale 1ns/1ns

module axil_write_front (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  axil_mem_pkg::addr_t   s_axil_awaddr,
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,
    input  axil_mem_pkg::data_t   s_axil_wdata,
    input  axil_mem_pkg::strb_t   s_axil_wstrb,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,
    output logic                  s_axil_bvalid,
    output axil_mem_pkg::resp_t   s_axil_bresp,
    input  logic                  s_axil_bready,
    output logic                  wr_en,
    output axil_mem_pkg::index_t  wr_index,
    output axil_mem_pkg::data_t   wr_data,
    output axil_mem_pkg::strb_t   wr_strb
);

    axil_mem_pkg::wr_state_t state, state_nxt;
    axil_mem_pkg::addr_t     aw_addr;     // Address hold
    axil_mem_pkg::data_t     w_data;      // Data hold
    axil_mem_pkg::strb_t     w_strb;
    logic aw_full, aw_full_nxt;
    logic w_full, w_full_nxt;
    logic aw_hs, w_hs;
    logic both_full;
    logic in_range;

    assign aw_hs     = s_axil_awvalid && s_axil_awready;
    assign w_hs      = s_axil_wvalid && s_axil_wready;
    assign both_full = aw_full && w_full;
    assign in_range  = aw_addr < axil_mem_pkg::MEM_BYTES;

    // RAM write fires in the one cycle where both halves are present
    assign wr_en    = (state == axil_mem_pkg::WR_COLLECT) && both_full && in_range;
    assign wr_index = aw_addr[axil_mem_pkg::INDEX_W+1:2];  // Low two bits dropped
    assign wr_data  = w_data;
    assign wr_strb  = w_strb;

    assign s_axil_bvalid = (state == axil_mem_pkg::WR_RESP);

    always_comb begin
        state_nxt   = state;
        aw_full_nxt = aw_full;
        w_full_nxt  = w_full;
        case (state)
            axil_mem_pkg::WR_COLLECT: begin
                if (aw_hs) aw_full_nxt = 1'b1;
                if (w_hs) w_full_nxt = 1'b1;
                if (both_full) state_nxt = axil_mem_pkg::WR_RESP;
            end
            axil_mem_pkg::WR_RESP: begin
                if (s_axil_bready) begin     // B accepted, free both holds
                    state_nxt   = axil_mem_pkg::WR_COLLECT;
                    aw_full_nxt = 1'b0;
                    w_full_nxt  = 1'b0;
                end
            end
            default: state_nxt = axil_mem_pkg::WR_COLLECT;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state          <= axil_mem_pkg::WR_COLLECT;
            aw_full        <= 1'b0;
            w_full         <= 1'b0;
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
        end else begin
            state          <= state_nxt;
            aw_full        <= aw_full_nxt;
            w_full         <= w_full_nxt;
            // Ready follows the hold being empty, one edge ahead
            s_axil_awready <= (state_nxt == axil_mem_pkg::WR_COLLECT) && !aw_full_nxt;
            s_axil_wready  <= (state_nxt == axil_mem_pkg::WR_COLLECT) && !w_full_nxt;
        end
    end

    // Payload holds
    always_ff @(posedge aclk) begin
        if (aw_hs) aw_addr <= s_axil_awaddr;
        if (w_hs) begin
            w_data <= s_axil_wdata;
            w_strb <= s_axil_wstrb;
        end
        if (state == axil_mem_pkg::WR_COLLECT && both_full) begin
            s_axil_bresp <= in_range ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
        end
    end

    // A pending B must not move or change its code before the master takes it
    assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp));

endmodule

// File: src/byte_lane_ram.sv
//--------------------
// Word RAM with per-byte write enables and a registered read port
//--------------------
`timescale 1ns/1ns

module byte_lane_ram (
    input  logic                  aclk,
    input  logic                  wr_en,
    input  axil_mem_pkg::index_t  wr_index,
    input  axil_mem_pkg::data_t   wr_data,
    input  axil_mem_pkg::strb_t   wr_strb,
    input  logic                  rd_en,
    input  axil_mem_pkg::index_t  rd_index,
    output axil_mem_pkg::data_t   rd_data
);

    axil_mem_pkg::data_t mem [axil_mem_pkg::MEM_WORDS];

    // Write port, each lane gated by its own strobe
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            for (int lane = 0; lane < axil_mem_pkg::STRB_W; lane++) begin
                if (wr_strb[lane]) begin
                    mem[wr_index][8*lane +: 8] <= wr_data[8*lane +: 8];
                end
            end
        end
    end

    // Read port
    // Output register only loads on rd_en, so the word stays put
    // while the read front waits on R back-pressure
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_index];   // Same-cycle write to this word gives old data
        end
    end

    // A write with a floating index would corrupt an unknown word
    assert property (@(posedge aclk) wr_en |-> !$isunknown(wr_index));

endmodule

// File: src/axil_read_front.sv
//--------------------
// AXI4-Lite read side: takes AR, reads the RAM once, holds R until accepted
//--------------------
`timescale 1ns/1ns

module axil_read_front (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  axil_mem_pkg::addr_t   s_axil_araddr,
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,
    output axil_mem_pkg::data_t   s_axil_rdata,
    output axil_mem_pkg::resp_t   s_axil_rresp,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,
    output logic                  rd_en,
    output axil_mem_pkg::index_t  rd_index,
    input  axil_mem_pkg::data_t   rd_data
);

    axil_mem_pkg::rd_state_t state, state_nxt;
    axil_mem_pkg::addr_t     ar_addr;
    logic ar_hs;
    logic in_range;

    assign ar_hs    = s_axil_arvalid && s_axil_arready;
    assign in_range = ar_addr < axil_mem_pkg::MEM_BYTES;

    assign rd_en    = (state == axil_mem_pkg::RD_FETCH) && in_range;
    assign rd_index = ar_addr[axil_mem_pkg::INDEX_W+1:2];

    // RAM output register is the data register of R
    assign s_axil_rdata  = in_range ? rd_data : '0;
    assign s_axil_rvalid = (state == axil_mem_pkg::RD_RESP);

    always_comb begin
        state_nxt = state;
        case (state)
            axil_mem_pkg::RD_IDLE:  if (ar_hs) state_nxt = axil_mem_pkg::RD_FETCH;
            axil_mem_pkg::RD_FETCH: state_nxt = axil_mem_pkg::RD_RESP;  // RAM answers next edge
            axil_mem_pkg::RD_RESP:  if (s_axil_rready) state_nxt = axil_mem_pkg::RD_IDLE;
            default:                state_nxt = axil_mem_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state          <= axil_mem_pkg::RD_IDLE;
            s_axil_arready <= 1'b0;
        end else begin
            state          <= state_nxt;
            s_axil_arready <= (state_nxt == axil_mem_pkg::RD_IDLE);
        end
    end

    // Address and response holds
    always_ff @(posedge aclk) begin
        if (ar_hs) ar_addr <= s_axil_araddr;
        if (state == axil_mem_pkg::RD_FETCH) begin
            s_axil_rresp <= in_range ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
        end
    end

    // Stalled R keeps its payload, which also relies on the RAM not
    // reloading its output register outside RD_FETCH
    assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_rvalid && !s_axil_rready |=>
            s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp));

endmodule

// File: src/axil_mem_top.sv
//--------------------
// AXI4-Lite slave memory, write and read fronts around one byte-lane RAM
//--------------------
`timescale 1ns/1ns

module axil_mem_top (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  axil_mem_pkg::addr_t  s_axil_awaddr,
    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  axil_mem_pkg::data_t  s_axil_wdata,
    input  axil_mem_pkg::strb_t  s_axil_wstrb,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    output logic                 s_axil_bvalid,
    output axil_mem_pkg::resp_t  s_axil_bresp,
    input  logic                 s_axil_bready,
    input  axil_mem_pkg::addr_t  s_axil_araddr,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    output axil_mem_pkg::data_t  s_axil_rdata,
    output axil_mem_pkg::resp_t  s_axil_rresp,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready
);

    // RAM write port
    logic                 wr_en;
    axil_mem_pkg::index_t wr_index;
    axil_mem_pkg::data_t  wr_data;
    axil_mem_pkg::strb_t  wr_strb;
    // RAM read port
    logic                 rd_en;
    axil_mem_pkg::index_t rd_index;
    axil_mem_pkg::data_t  rd_data;

    axil_write_front write_front0 (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bready  (s_axil_bready),
        .wr_en          (wr_en),
        .wr_index       (wr_index),
        .wr_data        (wr_data),
        .wr_strb        (wr_strb)
    );

    byte_lane_ram ram0 (
        .aclk     (aclk),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

    axil_read_front read_front0 (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .rd_en          (rd_en),
        .rd_index       (rd_index),
        .rd_data        (rd_data)
    );

endmodule

// File: sim/tb_axil_mem_util.svh
//--------------------
// LFSR source, word model of the memory and compare tasks for the testbench
// Included inside the testbench top module
//--------------------
`ifndef TB_AXIL_MEM_UTIL_SVH
`define TB_AXIL_MEM_UTIL_SVH

logic [31:0] lfsr_state = 32'hedec;
axil_mem_pkg::data_t model_mem [axil_mem_pkg::MEM_WORDS];
int test_errors = 0;                        // Mismatches in the running test

// Galois LFSR stepped once per bit handed out
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
endfunction

// Anything past the last word answers SLVERR
function automatic axil_mem_pkg::resp_t expected_resp(input axil_mem_pkg::addr_t a);
    return (a < axil_mem_pkg::MEM_BYTES) ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
endfunction

function automatic void model_write(input axil_mem_pkg::addr_t a, input axil_mem_pkg::data_t d,
                                    input axil_mem_pkg::strb_t s);
    int idx;
    if (a >= axil_mem_pkg::MEM_BYTES) return;    // Dropped write
    idx = a >> 2;
    for (int b = 0; b < axil_mem_pkg::STRB_W; b++) begin
        if (s[b]) model_mem[idx][8*b +: 8] = d[8*b +: 8];
    end
endfunction

function automatic axil_mem_pkg::data_t model_read(input axil_mem_pkg::addr_t a);
    if (a >= axil_mem_pkg::MEM_BYTES) return '0;
    return model_mem[a >> 2];
endfunction

task automatic report_fault(input string what);
    $display("[FAULT] %s", what);
    test_errors++;
endtask

task automatic check_data(input string name, input axil_mem_pkg::data_t exp,
                          input axil_mem_pkg::data_t act);
    if (act !== exp) begin
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        test_errors++;
    end
endtask

task automatic check_resp(input string name, input axil_mem_pkg::resp_t exp,
                          input axil_mem_pkg::resp_t act);
    if (act !== exp) begin
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        test_errors++;
    end
endtask

`endif

// File: sim/tb_axil_mem.sv
//--------------------
// Testbench for the AXI4-Lite memory with random traffic checked against a word model
//--------------------
`timescale 1ns/1ns

module tb_axil_mem;

    localparam int CLK_PERIOD     = 8;
    localparam int WATCH_TXNS     = 400;
    localparam int CYCLES_PER_TXN = 40;

    logic aclk;
    logic aresetn;
    axil_mem_pkg::addr_t s_axil_awaddr, s_axil_araddr;
    axil_mem_pkg::data_t s_axil_wdata, s_axil_rdata;
    axil_mem_pkg::strb_t s_axil_wstrb;
    axil_mem_pkg::resp_t s_axil_bresp, s_axil_rresp;
    logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic s_axil_bvalid, s_axil_bready;
    logic s_axil_arvalid, s_axil_arready, s_axil_rvalid, s_axil_rready;
    int tests_ok = 0;
    int tests_bad = 0;

    `include "tb_axil_mem_util.svh"

    axil_mem_top dut0 (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(WATCH_TXNS * CYCLES_PER_TXN * CLK_PERIOD);
        $display("Watchdog expired: the DUT stopped completing handshakes");
        $display("Test failed");
        $finish;
    end

    task automatic close_test(input string name);
        if (test_errors == 0) begin
            tests_ok++;
            $display("[done] %-16s ok", name);
        end else begin
            tests_bad++;
            $display("[done] %-16s %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Each channel starts at a falling edge where ready is stable until the next rise
    task automatic send_aw(input axil_mem_pkg::addr_t a, input int delay);
        repeat (delay) @(negedge aclk);
        s_axil_awaddr  = a;
        s_axil_awvalid = 1'b1;
        while (!s_axil_awready) @(negedge aclk);
        @(negedge aclk);
        s_axil_awvalid = 1'b0;
    endtask

    task automatic send_w(input axil_mem_pkg::data_t d, input axil_mem_pkg::strb_t s,
                          input int delay);
        repeat (delay) @(negedge aclk);
        s_axil_wdata  = d;
        s_axil_wstrb  = s;
        s_axil_wvalid = 1'b1;
        while (!s_axil_wready) @(negedge aclk);
        @(negedge aclk);
        s_axil_wvalid = 1'b0;
    endtask

    // Order 0 puts AW first, 1 puts W first, anything else sends both at once
    task automatic do_write(input string name, input axil_mem_pkg::addr_t a,
                            input axil_mem_pkg::data_t d, input axil_mem_pkg::strb_t s,
                            input int order, input int gap, input int stall);
        axil_mem_pkg::resp_t got;
        @(negedge aclk);
        fork
            send_aw(a, (order == 1) ? gap : 0);
            send_w(d, s, (order == 0) ? gap : 0);
        join
        while (!s_axil_bvalid) @(negedge aclk);
        got = s_axil_bresp;
        repeat (stall) begin
            @(negedge aclk);
            if (!s_axil_bvalid) report_fault({name, ": bvalid dropped while bready was low"});
            if (s_axil_awready || s_axil_wready) begin
                report_fault({name, ": AW or W ready during B stall"});
            end
            check_resp({name, " bresp hold"}, got, s_axil_bresp);
        end
        s_axil_bready = 1'b1;
        @(negedge aclk);
        s_axil_bready = 1'b0;
        check_resp({name, " bresp"}, expected_resp(a), got);
        model_write(a, d, s);
    endtask

    task automatic do_read(input string name, input axil_mem_pkg::addr_t a, input int stall);
        axil_mem_pkg::data_t got_d;
        axil_mem_pkg::resp_t got_r;
        @(negedge aclk);
        s_axil_araddr  = a;
        s_axil_arvalid = 1'b1;
        while (!s_axil_arready) @(negedge aclk);
        @(negedge aclk);
        s_axil_arvalid = 1'b0;
        while (!s_axil_rvalid) @(negedge aclk);
        got_d = s_axil_rdata;
        got_r = s_axil_rresp;
        repeat (stall) begin
            @(negedge aclk);
            if (!s_axil_rvalid) report_fault({name, ": rvalid dropped while rready was low"});
            if (s_axil_arready) report_fault({name, ": arready high during R stall"});
            check_data({name, " rdata hold"}, got_d, s_axil_rdata);
            check_resp({name, " rresp hold"}, got_r, s_axil_rresp);
        end
        s_axil_rready = 1'b1;
        @(negedge aclk);
        s_axil_rready = 1'b0;
        check_data({name, " rdata"}, model_read(a), got_d);
        check_resp({name, " rresp"}, expected_resp(a), got_r);
    endtask

    // Kind 0 full strobes, 1 partial strobes, 2 out of range,
    // 3 forced channel order, 4 random stalls and mixed traffic
    task automatic run_test(input string name, input int kind, input int count);
        axil_mem_pkg::addr_t a;
        axil_mem_pkg::addr_t ra;
        axil_mem_pkg::data_t d;
        axil_mem_pkg::strb_t s;
        int order;
        int gap;
        int b_stall;
        int r_stall;
        for (int i = 0; i < count; i++) begin
            a       = rand_bits(12);           // Word index plus the ignored low bits
            d       = rand_bits(32);
            s       = 4'hf;
            order   = 2;
            gap     = 0;
            b_stall = 0;
            r_stall = 0;
            if (kind == 1 || kind == 4) s = axil_mem_pkg::strb_t'(rand_bits(4));
            if (kind == 2 || (kind == 4 && rand_bits(3) == 0)) begin
                a = axil_mem_pkg::MEM_BYTES + rand_bits(31);
            end
            if (kind == 3) begin
                order = i % 3;
                gap   = 1 + rand_bits(3);
            end
            if (kind == 4) begin
                order   = rand_bits(2);
                gap     = rand_bits(3);
                b_stall = rand_bits(3);
                r_stall = rand_bits(3);
            end
            ra = (a & ~32'h3) | rand_bits(2);  // Same word through other low bits
            do_write(name, a, d, s, order, gap, b_stall);
            do_read(name, ra, r_stall);
            if (kind == 2) do_read(name, a % axil_mem_pkg::MEM_BYTES, 0);  // No wrap-around
        end
        close_test(name);
    endtask

    initial begin
        aresetn        = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        if (s_axil_bvalid || s_axil_rvalid) report_fault("bvalid or rvalid high in reset");
        aresetn = 1'b1;
        @(negedge aclk);
        if (!(s_axil_awready && s_axil_wready && s_axil_arready)) begin
            report_fault("a ready output stayed low after reset");
        end
        if (s_axil_bvalid || s_axil_rvalid) report_fault("bvalid or rvalid high after reset");
        close_test("reset_state");
        for (int i = 0; i < axil_mem_pkg::MEM_WORDS; i++) begin
            do_write("clear_memory", i * 4, '0, 4'hf, 2, 0, 0);
        end
        close_test("clear_memory");
        run_test("full_strobe_rw", 0, 40);
        run_test("partial_strobe", 1, 40);
        run_test("out_of_range", 2, 16);
        run_test("channel_order", 3, 30);
        run_test("stalls", 4, 40);
        $display("Tests: %0d ok, %0d failed", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+sim
src/axil_mem_pkg.sv
src/axil_write_front.sv
src/byte_lane_ram.sv
src/axil_read_front.sv
src/axil_mem_top.sv
sim/tb_axil_mem.sv
